// File: cpu_patterns.mem
// header: program words, data words, store pairs
// then program, initial data at address 0, store pairs as address value
00000024
00000003
00000009
// program
24010005 // addiu r1 r0 5
24220003 // addiu r2 r1 3
00411821 // addu  r3 r2 r1
00622023 // subu  r4 r3 r2
00832825 // or    r5 r4 r3
00A23024 // and   r6 r5 r2
0083382A // slt   r7 r4 r3
3C081234 // lui   r8 0x1234
35085678 // ori   r8 r8 0x5678
AC030040 // sw r3 0x40
AC060044 // sw r6 0x44
AC070048 // sw r7 0x48
AC08004C // sw r8 0x4c
8C090004 // lw r9 4
01215021 // addu r10 r9 r1, load use
AC0A0050 // sw r10 0x50
8C0B0000 // lw r11 0
AC0B0054 // sw r11 0x54, load use
10810002 // beq r4 r1 taken
AC010060 // skipped
AC020064 // skipped
14240002 // bne r1 r4 not taken
AC020058 // sw r2 0x58
0800001A // j to word 26
AC030068 // skipped
AC03006C // skipped
14220001 // bne r1 r2 taken
AC040070 // skipped
240DFFFF // addiu r13 r0 -1
340E8000 // ori r14 r0 0x8000
AC0D005C // sw r13 0x5c
AC0E0060 // sw r14 0x60
FC000000 // halt
AC010074 // behind halt, never stored
00000000
00000000
// data
00001234
FFFFFFF0
00000007
// expected stores
00000040 0000000D
00000044 00000008
00000048 00000001
0000004C 12345678
00000050 FFFFFFF5
00000054 00001234
00000058 00000008
0000005C FFFFFFFF
00000060 00008000

// File: files.f
cpu_pkg.sv
alu.sv
register_file.sv
control_unit.sv
forwarding_unit.sv
hazard_unit.sv
wb_mem_port.sv
datapath.sv
cpu_top.sv
tb_wb_memory.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - alu.sv
  - register_file.sv
  - control_unit.sv
  - forwarding_unit.sv
  - hazard_unit.sv
  - wb_mem_port.sv
  - datapath.sv
  - cpu_top.sv
  - target: simulation
    files:
      - tb_wb_memory.sv
      - tb_cpu.sv

// File: tb_cpu.sv
module tb_cpu
  import cpu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PAT_WORDS   = 128;
  localparam int HDR_WORDS   = 3;
  localparam int HALT_CHECKS = 20;

  logic    CLK;
  logic    nRST;
  wb_req_t ibus_req;
  wb_rsp_t ibus_rsp;
  wb_req_t dbus_req;
  wb_rsp_t dbus_rsp;
  logic    halt;

  logic [WORD_W-1:0] pat [0:PAT_WORDS-1];
  wb_req_t           exp_q [$];
  int                n_prog;
  int                n_data;
  int                n_stores;
  int                cycles = 0;
  int                limit  = 0;

  cpu_top dut_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .ibus_req (ibus_req),
    .ibus_rsp (ibus_rsp),
    .dbus_req (dbus_req),
    .dbus_rsp (dbus_rsp),
    .halt     (halt)
  );

  tb_wb_memory imem_i (.CLK(CLK), .nRST(nRST), .req(ibus_req), .rsp(ibus_rsp));
  tb_wb_memory dmem_i (.CLK(CLK), .nRST(nRST), .req(dbus_req), .rsp(dbus_rsp));

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // ------------------------------
  // failure reporting and checks
  // ------------------------------
  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_bus(input string name, input wb_req_t exp, input wb_req_t act);
    if (act !== exp) begin
      stop_with_error($sformatf(
        "FAILED %s expected we %b adr %h dat %h actual we %b adr %h dat %h",
        name, exp.we, exp.adr, exp.dat, act.we, act.adr, act.dat));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic load_patterns();
    wb_req_t st;
    $readmemh("cpu_patterns.mem", pat);
    if ($isunknown(pat[0])) begin
      stop_with_error("pattern file cpu_patterns.mem could not be read");
    end
    n_prog   = int'(pat[0]);
    n_data   = int'(pat[1]);
    n_stores = int'(pat[2]);
    imem_i.fill_pattern();
    dmem_i.fill_pattern();
    for (int k = 0; k < n_prog; k++) begin
      imem_i.mem[k] = pat[HDR_WORDS + k];
    end
    for (int k = 0; k < n_data; k++) begin
      dmem_i.mem[k] = pat[HDR_WORDS + n_prog + k];
    end
    // store pairs, address then value
    for (int k = 0; k < n_stores; k++) begin
      st     = '0;
      st.cyc = 1'b1;
      st.stb = 1'b1;
      st.we  = 1'b1;
      st.adr = pat[HDR_WORDS + n_prog + n_data + 2*k];
      st.dat = pat[HDR_WORDS + n_prog + n_data + 2*k + 1];
      st.sel = 4'hf;
      exp_q.push_back(st);
    end
    limit = (n_prog + n_stores) * 40;
  endtask

  // watchdog
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      stop_with_error($sformatf("timeout, no halt within %0d cycles", limit));
    end
  end

  // every acked data write, in program order
  always @(negedge CLK) begin
    if (nRST && dbus_req.cyc && dbus_req.stb && dbus_req.we && dbus_rsp.ack) begin
      if (halt) begin
        stop_with_error("data bus write seen after halt");
      end else if (exp_q.size() == 0) begin
        stop_with_error("data bus write beyond the expected stores");
      end else begin
        check_bus($sformatf("store_%0d", n_stores - exp_q.size()), exp_q[0], dbus_req);
        void'(exp_q.pop_front());
      end
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    wb_req_t first;
    nRST = 1'b0;
    load_patterns();
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_bit("reset_cyc", 1'b0, ibus_req.cyc);
    check_bit("reset_stb", 1'b0, ibus_req.stb);
    check_bit("reset_dbus_cyc", 1'b0, dbus_req.cyc);
    check_bit("reset_halt", 1'b0, halt);

    while (!ibus_req.stb) @(negedge CLK);
    first     = '0;
    first.cyc = 1'b1;
    first.stb = 1'b1;
    first.adr = PC_INIT;
    first.sel = 4'hf;
    check_bus("first_fetch", first, ibus_req);

    while (!halt) @(negedge CLK);
    if (exp_q.size() != 0) begin
      stop_with_error($sformatf("halt reached with %0d stores still missing", exp_q.size()));
    end

    repeat (HALT_CHECKS) begin
      @(negedge CLK);
      check_bit("halt_sticky", 1'b1, halt);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: tb_wb_memory.sv
module tb_wb_memory
  import cpu_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  wb_req_t req,
  output wb_rsp_t rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH = 256;

  logic [WORD_W-1:0] mem [0:DEPTH-1];
  integer            seed;
  logic              started;  // wait count drawn for the current cycle
  logic [1:0]        wait_cnt;

  initial begin
    seed = 32'ha5da_7840;
    rsp  = '0;
  end

  // background contents, a different word at every address
  task automatic fill_pattern();
    for (int k = 0; k < DEPTH; k++) begin
      mem[k] = {~k[15:0], k[15:0]};
    end
  endtask

  // ------------------------------
  // classic slave, 0 to 3 wait states
  // ------------------------------
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      rsp      <= '0;
      started  <= 1'b0;
      wait_cnt <= '0;
    end else begin
      rsp.ack <= 1'b0; // ack lasts one cycle
      if (req.cyc && req.stb && !rsp.ack) begin
        if (!started) begin
          started  <= 1'b1;
          wait_cnt <= 2'($random(seed));
        end else if (wait_cnt == '0) begin
          started <= 1'b0;
          rsp.ack <= 1'b1;
          rsp.dat <= mem[req.adr[9:2]];
          if (req.we) begin
            mem[req.adr[9:2]] <= req.dat;
          end
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end
  end

endmodule

// File: cpu_top.sv
module cpu_top
  import cpu_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  output wb_req_t ibus_req,
  input  wb_rsp_t ibus_rsp,
  output wb_req_t dbus_req,
  input  wb_rsp_t dbus_rsp,
  output logic    halt
);

  logic              imem_valid, imem_done;
  logic [WORD_W-1:0] imem_addr, imem_rdata;
  logic              dmem_valid, dmem_we, dmem_done;
  logic [WORD_W-1:0] dmem_addr, dmem_wdata, dmem_rdata;

  datapath datapath_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .imem_done  (imem_done),
    .imem_rdata (imem_rdata),
    .imem_valid (imem_valid),
    .imem_addr  (imem_addr),
    .dmem_done  (dmem_done),
    .dmem_rdata (dmem_rdata),
    .dmem_valid (dmem_valid),
    .dmem_we    (dmem_we),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .halt       (halt)
  );

  // instruction side is read only
  wb_mem_port ifetch_port_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_valid (imem_valid),
    .req_we    (1'b0),
    .req_addr  (imem_addr),
    .req_wdata ({WORD_W{1'b0}}),
    .done      (imem_done),
    .rdata     (imem_rdata),
    .bus_req   (ibus_req),
    .bus_rsp   (ibus_rsp)
  );

  wb_mem_port data_port_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_valid (dmem_valid),
    .req_we    (dmem_we),
    .req_addr  (dmem_addr),
    .req_wdata (dmem_wdata),
    .done      (dmem_done),
    .rdata     (dmem_rdata),
    .bus_req   (dbus_req),
    .bus_rsp   (dbus_rsp)
  );

endmodule

// File: datapath.sv
module datapath
  import cpu_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  logic              imem_done,
  input  logic [WORD_W-1:0] imem_rdata,
  output logic              imem_valid,
  output logic [WORD_W-1:0] imem_addr,
  input  logic              dmem_done,
  input  logic [WORD_W-1:0] dmem_rdata,
  output logic              dmem_valid,
  output logic              dmem_we,
  output logic [WORD_W-1:0] dmem_addr,
  output logic [WORD_W-1:0] dmem_wdata,
  output logic              halt
);

  logic [WORD_W-1:0] pc, pc_plus4;
  if_id_t  if_id, if_id_next;
  id_ex_t  id_ex, id_ex_next;
  ex_mem_t ex_mem, ex_mem_next;
  mem_wb_t mem_wb, mem_wb_next;

  logic              imem_got, dmem_got; // done seen while the other port still waits
  logic [WORD_W-1:0] imem_buf, dmem_buf;
  instr_u            fetch_word;
  logic [WORD_W-1:0] load_word;
  logic              dmem_active, advance, halt_q;

  ctrl_t             id_ctrl;
  logic [WORD_W-1:0] id_rdat1, id_rdat2, id_ext_imm;
  logic [WORD_W-1:0] wb_wdat;
  logic [1:0]        sel_a, sel_b;
  logic [WORD_W-1:0] op_a, op_b, alu_b, alu_y;
  logic              alu_zero;
  logic              mem_take;
  logic [WORD_W-1:0] br_target, redirect;
  logic              pc_hold, if_id_hold, id_ex_bubble, flush;

  // ------------------------------
  // bus handshake and stall
  // ------------------------------
  assign dmem_active = ex_mem.ctrl.mem_rd || ex_mem.ctrl.mem_wr;
  assign advance = (imem_done || imem_got) && !halt &&
                   (!dmem_active || dmem_done || dmem_got);

  assign imem_valid = !halt && !imem_got;
  assign imem_addr  = pc;
  assign dmem_valid = dmem_active && !dmem_got && !halt;
  assign dmem_we    = ex_mem.ctrl.mem_wr;
  assign dmem_addr  = ex_mem.alu_out;
  assign dmem_wdata = ex_mem.store_data;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      imem_got <= 1'b0;
      dmem_got <= 1'b0;
    end else if (advance) begin
      imem_got <= 1'b0;
      dmem_got <= 1'b0;
    end else begin
      if (imem_done) imem_got <= 1'b1;
      if (dmem_done) dmem_got <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (imem_done) imem_buf <= imem_rdata;
    if (dmem_done) dmem_buf <= dmem_rdata;
  end

  assign fetch_word = imem_got ? imem_buf : imem_rdata;
  assign load_word  = dmem_got ? dmem_buf : dmem_rdata;

  // fetch
  assign pc_plus4 = pc + WORD_W'(4);
  assign if_id_next.pc_plus4 = pc_plus4;
  assign if_id_next.instr    = fetch_word;

  // ------------------------------
  // decode
  // ------------------------------
  control_unit control_unit_i (.instr(if_id.instr), .ctrl(id_ctrl));

  register_file register_file_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .we    (mem_wb.ctrl.reg_wr),
    .wsel  (mem_wb.wsel),
    .rsel1 (if_id.instr.i.rs),
    .rsel2 (if_id.instr.i.rt),
    .wdat  (wb_wdat),
    .rdat1 (id_rdat1),
    .rdat2 (id_rdat2)
  );

  assign id_ext_imm = id_ctrl.ext_signed ?
                      {{16{if_id.instr.i.imm16[15]}}, if_id.instr.i.imm16} :
                      {16'h0000, if_id.instr.i.imm16};

  always_comb begin
    id_ex_next.ctrl     = id_ctrl;
    id_ex_next.pc_plus4 = if_id.pc_plus4;
    id_ex_next.rdat1    = id_rdat1;
    id_ex_next.rdat2    = id_rdat2;
    id_ex_next.ext_imm  = id_ext_imm;
    id_ex_next.rs       = if_id.instr.i.rs;
    id_ex_next.rt       = if_id.instr.i.rt;
    id_ex_next.rd       = if_id.instr.r.rd;
    id_ex_next.instr    = if_id.instr;
  end

  hazard_unit hazard_unit_i (
    .id_rs        (if_id.instr.i.rs),
    .id_rt        (if_id.instr.i.rt),
    .ex_rt        (id_ex.rt),
    .ex_mem_rd    (id_ex.ctrl.mem_rd),
    .mem_take     (mem_take),
    .pc_hold      (pc_hold),
    .if_id_hold   (if_id_hold),
    .id_ex_bubble (id_ex_bubble),
    .flush        (flush)
  );

  // execute
  forwarding_unit forwarding_unit_i (
    .ex_rs      (id_ex.rs),
    .ex_rt      (id_ex.rt),
    .mem_wsel   (ex_mem.wsel),
    .wb_wsel    (mem_wb.wsel),
    .mem_reg_wr (ex_mem.ctrl.reg_wr),
    .wb_reg_wr  (mem_wb.ctrl.reg_wr),
    .sel_a      (sel_a),
    .sel_b      (sel_b)
  );

  always_comb begin
    case (sel_a)
      FWD_MEM: op_a = ex_mem.alu_out;
      FWD_WB:  op_a = wb_wdat;
      default: op_a = id_ex.rdat1;
    endcase
    case (sel_b)
      FWD_MEM: op_b = ex_mem.alu_out;
      FWD_WB:  op_b = wb_wdat;
      default: op_b = id_ex.rdat2;
    endcase
  end

  assign alu_b = id_ex.ctrl.alu_src ? id_ex.ext_imm : op_b;

  alu alu_i (.a(op_a), .b(alu_b), .op(id_ex.ctrl.alu_op), .y(alu_y), .zero(alu_zero));

  always_comb begin
    ex_mem_next.ctrl       = id_ex.ctrl;
    ex_mem_next.pc_plus4   = id_ex.pc_plus4;
    ex_mem_next.alu_out    = alu_y;
    ex_mem_next.zero       = alu_zero;
    ex_mem_next.store_data = op_b; // forwarded rt for sw
    ex_mem_next.wsel       = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
    ex_mem_next.ext_imm    = id_ex.ext_imm;
    ex_mem_next.jaddr      = {id_ex.pc_plus4[WORD_W-1:28], id_ex.instr.j.addr26, 2'b00};
  end

  // memory stage resolves control flow
  assign mem_take = ex_mem.ctrl.jump ||
                    (ex_mem.ctrl.branch_eq && ex_mem.zero) ||
                    (ex_mem.ctrl.branch_ne && !ex_mem.zero);
  assign br_target = ex_mem.pc_plus4 + {ex_mem.ext_imm[WORD_W-3:0], 2'b00};
  assign redirect  = ex_mem.ctrl.jump ? ex_mem.jaddr : br_target;

  always_comb begin
    mem_wb_next.ctrl      = ex_mem.ctrl;
    mem_wb_next.alu_out   = ex_mem.alu_out;
    mem_wb_next.load_data = load_word;
    mem_wb_next.wsel      = ex_mem.wsel;
  end

  assign wb_wdat = mem_wb.ctrl.mem_to_reg ? mem_wb.load_data : mem_wb.alu_out;

  // ------------------------------
  // pc and stage registers
  // ------------------------------
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc     <= PC_INIT;
      if_id  <= '0;
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else if (advance) begin
      mem_wb <= mem_wb_next;
      if (flush) begin
        pc     <= redirect;
        if_id  <= '0;
        id_ex  <= '0;
        ex_mem <= '0;
      end else begin
        if (!pc_hold) pc <= pc_plus4;
        if (!if_id_hold) if_id <= if_id_next;
        id_ex  <= id_ex_bubble ? '0 : id_ex_next;
        ex_mem <= ex_mem_next;
      end
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      halt_q <= 1'b0;
    end else if (mem_wb.ctrl.halt) begin
      halt_q <= 1'b1; // sticky until reset
    end
  end

  assign halt = halt_q || mem_wb.ctrl.halt;

endmodule

// File: wb_mem_port.sv
module wb_mem_port
  import cpu_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  logic              req_valid,
  input  logic              req_we,
  input  logic [WORD_W-1:0] req_addr,
  input  logic [WORD_W-1:0] req_wdata,
  output logic              done,
  output logic [WORD_W-1:0] rdata,
  output wb_req_t           bus_req,
  input  wb_rsp_t           bus_rsp
);

  logic              busy; // 0 idle, 1 waiting for ack
  logic              we_q;
  logic [WORD_W-1:0] adr_q;
  logic [WORD_W-1:0] dat_q;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
      we_q <= 1'b0;
    end else if (busy) begin
      if (bus_rsp.ack) begin
        busy <= 1'b0; // stb drops after the ack cycle
      end
    end else if (req_valid) begin
      busy <= 1'b1;
      we_q <= req_we;
    end
  end

  // request captured at launch, held until ack
  always_ff @(posedge CLK) begin
    if (!busy && req_valid) begin
      adr_q <= req_addr;
      dat_q <= req_wdata;
    end
  end

  assign bus_req.cyc = busy;
  assign bus_req.stb = busy;
  assign bus_req.we  = we_q;
  assign bus_req.adr = adr_q;
  assign bus_req.dat = dat_q;
  assign bus_req.sel = '1;

  assign done  = busy && bus_rsp.ack;
  assign rdata = bus_rsp.dat;

  a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (bus_req.stb && !bus_rsp.ack) |=>
      ($stable(bus_req.adr) && $stable(bus_req.dat) && $stable(bus_req.we)));

  a_ack_needs_stb: assert property (@(posedge CLK) disable iff (!nRST)
    bus_rsp.ack |-> bus_req.stb);

endmodule

// File: hazard_unit.sv
module hazard_unit
  import cpu_pkg::*;
(
  input  logic [REG_W-1:0] id_rs,
  input  logic [REG_W-1:0] id_rt,
  input  logic [REG_W-1:0] ex_rt,
  input  logic             ex_mem_rd,  // load sitting in execute
  input  logic             mem_take,   // redirect from memory stage
  output logic             pc_hold,
  output logic             if_id_hold,
  output logic             id_ex_bubble,
  output logic             flush
);

  logic load_use;

  // the load writes rt and decode may read it as rs or rt
  assign load_use = ex_mem_rd && (ex_rt != '0) &&
                    ((ex_rt == id_rs) || (ex_rt == id_rt));

  // a redirect discards the dependent instruction anyway
  assign pc_hold      = load_use && !mem_take;
  assign if_id_hold   = load_use && !mem_take;
  assign id_ex_bubble = load_use && !mem_take;
  assign flush        = mem_take;

endmodule

// File: forwarding_unit.sv
module forwarding_unit
  import cpu_pkg::*;
(
  input  logic [REG_W-1:0] ex_rs,
  input  logic [REG_W-1:0] ex_rt,
  input  logic [REG_W-1:0] mem_wsel,
  input  logic [REG_W-1:0] wb_wsel,
  input  logic             mem_reg_wr,
  input  logic             wb_reg_wr,
  output logic [1:0]       sel_a,
  output logic [1:0]       sel_b
);

  // memory stage is younger so it wins
  function automatic logic [1:0] pick(input logic [REG_W-1:0] src);
    logic [1:0] sel;
    sel = FWD_REG;
    if (src != '0) begin
      if (mem_reg_wr && mem_wsel == src) begin
        sel = FWD_MEM;
      end else if (wb_reg_wr && wb_wsel == src) begin
        sel = FWD_WB;
      end
    end
    return sel;
  endfunction

  assign sel_a = pick(ex_rs);
  assign sel_b = pick(ex_rt);

endmodule

// File: control_unit.sv
module control_unit
  import cpu_pkg::*;
(
  input  instr_u instr,
  output ctrl_t  ctrl
);

  always_comb begin
    ctrl = '0; // unknown codes fall through as nop
    case (instr.r.opcode)
      OP_RTYPE: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.reg_dst = 1'b1;
        case (instr.r.funct)
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          default: ctrl = '0;
        endcase
      end
      OP_ADDIU: begin
        ctrl.reg_wr     = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.ext_signed = 1'b1;
        ctrl.alu_op     = ALU_ADD;
      end
      OP_ORI: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.alu_op  = ALU_OR; // zero extended
      end
      OP_LUI: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.alu_op  = ALU_LUI;
      end
      OP_LW: begin
        ctrl.reg_wr     = 1'b1;
        ctrl.mem_rd     = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.ext_signed = 1'b1;
        ctrl.alu_op     = ALU_ADD;
      end
      OP_SW: begin
        ctrl.mem_wr     = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.ext_signed = 1'b1;
        ctrl.alu_op     = ALU_ADD;
      end
      OP_BEQ, OP_BNE: begin
        ctrl.branch_eq  = (instr.r.opcode == OP_BEQ);
        ctrl.branch_ne  = (instr.r.opcode == OP_BNE);
        ctrl.ext_signed = 1'b1;
        ctrl.alu_op     = ALU_SUB; // zero flag compares rs and rt
      end
      OP_J:    ctrl.jump = 1'b1;
      OP_HALT: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

// File: register_file.sv
module register_file
  import cpu_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  logic              we,
  input  logic [REG_W-1:0]  wsel,
  input  logic [REG_W-1:0]  rsel1,
  input  logic [REG_W-1:0]  rsel2,
  input  logic [WORD_W-1:0] wdat,
  output logic [WORD_W-1:0] rdat1,
  output logic [WORD_W-1:0] rdat2
);

  logic [WORD_W-1:0] regs [0:2**REG_W-1]; // r0 never written

  // falling edge write so decode sees the new value in the same cycle
  always_ff @(negedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int k = 0; k < 2**REG_W; k++) begin
        regs[k] <= '0;
      end
    end else if (we && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

  a_r0_zero: assert property (@(posedge CLK) disable iff (!nRST)
    (rsel1 == '0) |-> (rdat1 == '0));

endmodule

// File: alu.sv
module alu
  import cpu_pkg::*;
(
  input  logic [WORD_W-1:0] a,
  input  logic [WORD_W-1:0] b,
  input  aluop_t            op,
  output logic [WORD_W-1:0] y,
  output logic              zero
);

  always_comb begin
    case (op)
      ALU_ADD: y = a + b;
      ALU_SUB: y = a - b;
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_SLT: begin
        // signed compare
        y = ($signed(a) < $signed(b)) ? WORD_W'(1) : '0;
      end
      ALU_LUI: y = {b[15:0], 16'h0000}; // immediate into upper half
      default: y = '0;
    endcase
  end

  assign zero = (y == '0); // beq/bne decision

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

  // ------------------------------
  // widths and reset values
  // ------------------------------
  localparam int unsigned WORD_W = 32;
  localparam int unsigned REG_W  = 5;
  localparam logic [WORD_W-1:0] PC_INIT = '0;

  // forwarding mux selects
  localparam logic [1:0] FWD_REG = 2'b00;
  localparam logic [1:0] FWD_MEM = 2'b01;
  localparam logic [1:0] FWD_WB  = 2'b10;

  // ------------------------------
  // instruction encodings
  // ------------------------------
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0D,
    OP_LUI   = 6'h0F,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B,
    OP_HALT  = 6'h3F
  } opcode_t;

  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2A
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,
    ALU_LUI = 3'd5
  } aluop_t;

  typedef struct packed {
    opcode_t          opcode;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [REG_W-1:0] rd;
    logic [4:0]       shamt;
    funct_t           funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_t          opcode;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [15:0]      imm16;
  } i_fmt_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr26;
  } j_fmt_t;

  // one instruction word, three field layouts
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_u;

  typedef struct packed {
    logic   reg_wr;
    logic   mem_rd;
    logic   mem_wr;
    logic   mem_to_reg;
    logic   alu_src;    // immediate as operand b
    logic   reg_dst;    // rd instead of rt
    logic   ext_signed;
    logic   branch_eq;
    logic   branch_ne;
    logic   jump;
    logic   halt;
    aluop_t alu_op;
  } ctrl_t;

  // ------------------------------
  // pipeline registers
  // ------------------------------
  typedef struct packed {
    logic [WORD_W-1:0] pc_plus4;
    instr_u            instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t             ctrl;
    logic [WORD_W-1:0] pc_plus4;
    logic [WORD_W-1:0] rdat1;
    logic [WORD_W-1:0] rdat2;
    logic [WORD_W-1:0] ext_imm;
    logic [REG_W-1:0]  rs;
    logic [REG_W-1:0]  rt;
    logic [REG_W-1:0]  rd;
    instr_u            instr;
  } id_ex_t;

  typedef struct packed {
    ctrl_t             ctrl;
    logic [WORD_W-1:0] pc_plus4;
    logic [WORD_W-1:0] alu_out;
    logic              zero;
    logic [WORD_W-1:0] store_data;
    logic [REG_W-1:0]  wsel;
    logic [WORD_W-1:0] ext_imm;
    logic [WORD_W-1:0] jaddr;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t             ctrl;
    logic [WORD_W-1:0] alu_out;
    logic [WORD_W-1:0] load_data;
    logic [REG_W-1:0]  wsel;
  } mem_wb_t;

  // wishbone classic
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [WORD_W-1:0] adr;
    logic [WORD_W-1:0] dat;
    logic [3:0]        sel;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [WORD_W-1:0] dat;
  } wb_rsp_t;

endpackage
